// ==== build.f ====
hw/scr_pkg.sv
hw/scr_regs_if.sv
hw/scr_apb_regs.sv
hw/scr_tile_fetch.sv
hw/scr_linebuf.sv
hw/scr_layer_top.sv
tests/scr_checker.sv
tests/tb_scr_layer.sv

// ==== hw/scr_apb_regs.sv ====
`default_nettype none

module scr_apb_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [scr_pkg::apb_addr_w-1:0] paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    scr_regs_if.regs                       regs
);

    logic [15:0]                      pages_q;
    logic [scr_pkg::plane_w_bits-1:0] hscr_q;
    logic [scr_pkg::plane_h_bits-1:0] vscr_q;
    logic [scr_pkg::plane_w_bits-1:0] rowscr_q;
    logic [1:0]                       ctrl_q;    // {rowscr_en, flip}
    logic                             access;
    logic                             addr_ok;
    logic                             wr_en;

    assign access  = psel & penable;             // access phase
    assign addr_ok = paddr <= scr_pkg::reg_ctrl;
    assign wr_en   = access & pwrite & addr_ok;  // bad address writes nothing

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pages_q  <= '0;
            hscr_q   <= '0;
            vscr_q   <= '0;
            rowscr_q <= '0;
            ctrl_q   <= '0;
        end else if (wr_en) begin
            case (paddr)
                scr_pkg::reg_pages:  pages_q  <= pwdata[15:0];
                scr_pkg::reg_hscr:   hscr_q   <= pwdata[scr_pkg::plane_w_bits-1:0];
                scr_pkg::reg_vscr:   vscr_q   <= pwdata[scr_pkg::plane_h_bits-1:0];
                scr_pkg::reg_rowscr: rowscr_q <= pwdata[scr_pkg::plane_w_bits-1:0];
                default:             ctrl_q   <= pwdata[1:0]; // only reg_ctrl left
            endcase
        end
    end

    // read mux, upper bits zero
    always_comb begin
        prdata = '0;
        case (paddr)
            scr_pkg::reg_pages:  prdata[15:0] = pages_q;
            scr_pkg::reg_hscr:   prdata[scr_pkg::plane_w_bits-1:0] = hscr_q;
            scr_pkg::reg_vscr:   prdata[scr_pkg::plane_h_bits-1:0] = vscr_q;
            scr_pkg::reg_rowscr: prdata[scr_pkg::plane_w_bits-1:0] = rowscr_q;
            scr_pkg::reg_ctrl:   prdata[1:0] = ctrl_q;
            default:             prdata = '0;
        endcase
    end

    assign pready  = 1'b1;                       // zero wait states
    assign pslverr = access & ~addr_ok;

    // live values out to the fetcher
    assign regs.pages     = pages_q;
    assign regs.hscr      = hscr_q;
    assign regs.vscr      = vscr_q;
    assign regs.rowscr    = rowscr_q;
    assign regs.flip      = ctrl_q[0];
    assign regs.rowscr_en = ctrl_q[1];

    // setup phase must come first
    a_setup_first: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> $past(psel)
    );

    // address held from setup into access
    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        psel && penable |-> $stable(paddr)
    );

endmodule

`default_nettype wire

// ==== hw/scr_layer_top.sv ====
`default_nettype none

module scr_layer_top (
    input  logic                            clk,
    input  logic                            rst,
    // APB
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [scr_pkg::apb_addr_w-1:0]  paddr,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    // tile map memory
    output logic                            map_cs,
    output logic [scr_pkg::map_addr_w-1:0]  map_addr,
    input  logic [15:0]                     map_data,
    input  logic                            map_ok,
    // tile graphics memory
    output logic                            tile_cs,
    output logic [scr_pkg::tile_addr_w-1:0] tile_addr,
    input  logic [31:0]                     tile_data,
    input  logic                            tile_ok,
    // video timing
    input  logic                            lhbl,
    input  logic [8:0]                      vrender,
    input  logic [8:0]                      hdump,
    output scr_pkg::pixel_t                 pxl
);

    logic [7:0]      wr_addr;
    scr_pkg::pixel_t wr_data;
    logic            we;

    scr_regs_if u_regs_if ();

    // register block
    scr_apb_regs u_apb_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .regs    (u_regs_if.regs)
    );

    // renders one line per blank
    scr_tile_fetch u_tile_fetch (
        .clk       (clk),
        .rst       (rst),
        .regs      (u_regs_if.fetch),
        .lhbl      (lhbl),
        .vrender   (vrender),
        .map_cs    (map_cs),
        .map_addr  (map_addr),
        .map_data  (map_data),
        .map_ok    (map_ok),
        .tile_cs   (tile_cs),
        .tile_addr (tile_addr),
        .tile_data (tile_data),
        .tile_ok   (tile_ok),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .we        (we)
    );

    // shows previous line
    scr_linebuf u_linebuf (
        .clk     (clk),
        .rst     (rst),
        .lhbl    (lhbl),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .we      (we),
        .hdump   (hdump),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

// ==== hw/scr_linebuf.sv ====
`default_nettype none

module scr_linebuf (
    input  logic            clk,
    input  logic            rst,
    input  logic            lhbl,
    // fetcher side
    input  logic [7:0]      wr_addr,
    input  scr_pkg::pixel_t wr_data,
    input  logic            we,
    // display side
    input  logic [8:0]      hdump,
    output scr_pkg::pixel_t pxl
);

    scr_pkg::pixel_t mem [0:2*scr_pkg::line_w-1];  // two banks back to back

    logic       wr_bank;      // display uses the other one
    logic       last_lhbl;
    logic       blank_start;
    logic [1:0] bank_vld;     // bank written since reset
    logic       rd_en;
    logic [8:0] wr_idx;
    logic [8:0] rd_idx;

    assign blank_start = last_lhbl & ~lhbl;
    assign rd_en  = lhbl && (hdump < scr_pkg::line_w);
    assign wr_idx = {wr_bank, wr_addr};
    assign rd_idx = {~wr_bank, hdump[7:0]};

    // write new line, erase what was shown
    always_ff @(posedge clk) begin
        if (we)
            mem[wr_idx] <= wr_data;
        if (rd_en)
            mem[rd_idx] <= '0;   // other bank, never the write slot
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_bank   <= 1'b0;
            last_lhbl <= 1'b0;
            bank_vld  <= '0;
            pxl       <= '0;
        end else begin
            last_lhbl <= lhbl;
            if (blank_start)
                wr_bank <= ~wr_bank;            // swap banks
            if (we)
                bank_vld[wr_bank] <= 1'b1;
            // unwritten bank shows as blank
            if (rd_en && bank_vld[~wr_bank])
                pxl <= mem[rd_idx];
            else
                pxl <= '0;
        end
    end

    // fetcher must have finished before the swap
    a_no_write_on_swap: assert property (
        @(posedge clk) disable iff (rst)
        blank_start |-> !we
    );

endmodule

`default_nettype wire

// ==== hw/scr_pkg.sv ====
`default_nettype none

package scr_pkg;

    // line geometry
    localparam int line_w = 256;             // visible pixels per line

    // scroll plane is 2x2 pages
    localparam int plane_w_bits = 10;        // 1024 pixel wide plane
    localparam int plane_h_bits = 9;         // 512 lines tall
    localparam int page_cols    = 64;        // tiles across one page
    localparam int page_rows    = 32;        // tiles down one page
    localparam int col_bits     = $clog2(page_cols);
    localparam int row_bits     = $clog2(page_rows);

    // external memories
    localparam int map_addr_w  = 15;         // 4 page + 5 row + 6 col
    localparam int tile_addr_w = 16;         // 13 code + 3 tile row

    // APB word addresses
    localparam int apb_addr_w = 5;
    localparam logic [apb_addr_w-1:0] reg_pages  = 5'd0; // four page nibbles
    localparam logic [apb_addr_w-1:0] reg_hscr   = 5'd1;
    localparam logic [apb_addr_w-1:0] reg_vscr   = 5'd2;
    localparam logic [apb_addr_w-1:0] reg_rowscr = 5'd3;
    localparam logic [apb_addr_w-1:0] reg_ctrl   = 5'd4; // bit0 flip, bit1 rowscr_en

    // one line buffer entry
    // 1 priority + 7 palette + 3 colour
    typedef struct packed {
        logic       prio;
        logic [6:0] pal;
        logic [2:0] color;
    } pixel_t;

endpackage

`default_nettype wire

// ==== hw/scr_regs_if.sv ====
`default_nettype none

// live register values, register block to fetcher
interface scr_regs_if;

    logic [15:0]                      pages;     // UL, UR, LL, LR nibbles
    logic [scr_pkg::plane_w_bits-1:0] hscr;
    logic [scr_pkg::plane_h_bits-1:0] vscr;
    logic [scr_pkg::plane_w_bits-1:0] rowscr;    // replaces hscr when enabled
    logic                             rowscr_en;
    logic                             flip;

    modport regs (
        output pages, hscr, vscr, rowscr, rowscr_en, flip
    );

    // fetcher snapshots these at blank start
    modport fetch (
        input pages, hscr, vscr, rowscr, rowscr_en, flip
    );

endinterface

`default_nettype wire

// ==== hw/scr_tile_fetch.sv ====
`default_nettype none

module scr_tile_fetch (
    input  logic                            clk,
    input  logic                            rst,
    scr_regs_if.fetch                       regs,
    input  logic                            lhbl,
    input  logic [8:0]                      vrender,
    // tile map memory
    output logic                            map_cs,
    output logic [scr_pkg::map_addr_w-1:0]  map_addr,
    input  logic [15:0]                     map_data,
    input  logic                            map_ok,
    // tile graphics memory
    output logic                            tile_cs,
    output logic [scr_pkg::tile_addr_w-1:0] tile_addr,
    input  logic [31:0]                     tile_data,
    input  logic                            tile_ok,
    // line buffer write side
    output logic [7:0]                      wr_addr,
    output scr_pkg::pixel_t                 wr_data,
    output logic                            we
);

    typedef enum logic [1:0] {
        st_idle,
        st_map,      // waiting for map word
        st_tile,     // waiting for tile row
        st_shift     // one pixel per clock
    } state_t;

    state_t                           state;
    logic                             last_lhbl;
    logic                             blank_start;
    logic                             done;
    logic [7:0]                       col;        // output column
    logic [scr_pkg::plane_w_bits-1:0] px;         // plane x of current pixel
    logic [scr_pkg::plane_w_bits-1:0] px_nxt;
    logic [scr_pkg::plane_h_bits-1:0] py;         // plane y of this line
    logic [15:0]                      pages_s;
    logic                             flip_s;
    logic                             prio_r;
    logic [6:0]                       pal_r;
    logic [7:0]                       plane2, plane1, plane0;
    logic [8:0]                       row;
    logic [scr_pkg::plane_w_bits-1:0] start_x;
    logic [scr_pkg::plane_h_bits-1:0] start_y;
    logic                             tile_end;

    // map word address for a plane position
    function automatic logic [scr_pkg::map_addr_w-1:0] map_of(
        input logic [scr_pkg::plane_w_bits-1:0] x,
        input logic [scr_pkg::plane_h_bits-1:0] y,
        input logic [15:0]                      pg
    );
        logic [3:0] page;
        case ({y[scr_pkg::plane_h_bits-1], x[scr_pkg::plane_w_bits-1]})
            2'b00:   page = pg[15:12];   // upper left
            2'b01:   page = pg[11:8];    // upper right
            2'b10:   page = pg[7:4];     // lower left
            default: page = pg[3:0];     // lower right
        endcase
        return {page, y[scr_pkg::row_bits+2:3], x[scr_pkg::col_bits+2:3]};
    endfunction

    assign blank_start = last_lhbl & ~lhbl;
    assign row      = regs.flip ? 9'd223 - vrender : vrender;
    assign start_x  = regs.rowscr_en ? regs.rowscr : regs.hscr;
    assign start_y  = row + regs.vscr;   // wraps inside the plane
    assign px_nxt   = px + 1'b1;
    assign tile_end = px[2:0] == 3'd7;

    // control path
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            last_lhbl <= 1'b0;
            done      <= 1'b0;
            col       <= '0;
            map_cs    <= 1'b0;
            tile_cs   <= 1'b0;
        end else begin
            last_lhbl <= lhbl;
            if (blank_start) begin       // new line, first map read
                state   <= st_map;
                done    <= 1'b0;
                col     <= '0;
                map_cs  <= 1'b1;
                tile_cs <= 1'b0;
            end else begin
                case (state)
                    st_map: if (map_ok) begin
                        map_cs  <= 1'b0;
                        tile_cs <= 1'b1;
                        state   <= st_tile;
                    end
                    st_tile: if (tile_ok) begin
                        tile_cs <= 1'b0;
                        state   <= st_shift;
                    end
                    st_shift: begin
                        col <= col + 1'b1;
                        if (col == 8'(scr_pkg::line_w - 1)) begin
                            done  <= 1'b1;   // 256 writes
                            state <= st_idle;
                        end else if (tile_end) begin
                            map_cs <= 1'b1;  // next tile
                            state  <= st_map;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (blank_start) begin
            flip_s   <= regs.flip;
            pages_s  <= regs.pages;
            px       <= start_x;
            py       <= start_y;
            map_addr <= map_of(start_x, start_y, regs.pages);
        end else begin
            case (state)
                st_map: if (map_ok) begin
                    prio_r    <= map_data[15];
                    pal_r     <= map_data[11:5];
                    tile_addr <= {map_data[12:0], py[2:0]};
                end
                st_tile: if (tile_ok) begin
                    // first tile of a line may start mid tile
                    plane2 <= tile_data[23:16] << px[2:0];
                    plane1 <= tile_data[15:8] << px[2:0];
                    plane0 <= tile_data[7:0] << px[2:0];
                end
                st_shift: begin
                    px     <= px_nxt;
                    plane2 <= plane2 << 1;
                    plane1 <= plane1 << 1;
                    plane0 <= plane0 << 1;
                    if (tile_end)
                        map_addr <= map_of(px_nxt, py, pages_s);
                end
                default: ;
            endcase
        end
    end

    // one write per shifted pixel
    assign we      = state == st_shift;
    assign wr_addr = flip_s ? 8'(scr_pkg::line_w - 1) - col : col; // mirror
    assign wr_data = {prio_r, pal_r, plane2[7], plane1[7], plane0[7]};

    // map and tile requests never overlap
    a_no_overlap: assert property (
        @(posedge clk) disable iff (rst)
        $rose(tile_cs) |-> !map_cs
    );

    // nothing written once the line is complete
    a_no_write_done: assert property (
        @(posedge clk) disable iff (rst)
        done |-> !we
    );

endmodule

`default_nettype wire

// ==== tests/scr_checker.sv ====
`default_nettype none

module scr_checker (
    input  logic            clk,
    input  logic            rst,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [4:0]      paddr,
    input  logic [31:0]     pwdata,
    input  logic [31:0]     prdata,
    input  logic            pready,
    input  logic            pslverr,
    input  logic            map_cs,
    input  logic            tile_cs,
    input  logic            lhbl,
    input  logic [8:0]      vrender,
    input  logic [8:0]      hdump,
    input  scr_pkg::pixel_t pxl,
    output int              pix_errs,
    output int              apb_errs
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int line_w = 256;

    // register model
    logic [15:0] m_pages;
    logic [9:0]  m_hscr;
    logic [8:0]  m_vscr;
    logic [9:0]  m_rowscr;
    logic [1:0]  m_ctrl;              // {rowscr_en, flip}

    logic [10:0] disp [0:line_w-1];   // line on display
    logic [10:0] pend [0:line_w-1];   // line being rendered
    logic        last_lhbl;
    logic        seen_blank;
    logic        chk_pend;
    logic [10:0] exp_pxl;
    logic [7:0]  exp_col;

    initial begin
        pix_errs = 0;
        apb_errs = 0;
    end

    function automatic logic [31:0] reg_value(input logic [4:0] a);
        case (a)
            5'd0:    return {16'h0, m_pages};
            5'd1:    return {22'h0, m_hscr};
            5'd2:    return {23'h0, m_vscr};
            5'd3:    return {22'h0, m_rowscr};
            5'd4:    return {30'h0, m_ctrl};
            default: return 32'h0;     // unmapped reads as zero
        endcase
    endfunction

    // reference renderer for one line, from the current register model
    task automatic render_line(input logic [8:0] vr);
        logic [8:0]  row;
        logic [8:0]  y;
        logic [9:0]  x;
        logic [3:0]  page;
        logic [15:0] mw;
        logic [31:0] tw;
        int          b;
        int          dest;
        row = m_ctrl[0] ? 9'd223 - vr : vr;
        y   = row + m_vscr;
        for (int c = 0; c < line_w; c++) begin
            x = (m_ctrl[1] ? m_rowscr : m_hscr) + 10'(c);
            case ({y[8], x[9]})
                2'b00:   page = m_pages[15:12];
                2'b01:   page = m_pages[11:8];
                2'b10:   page = m_pages[7:4];
                default: page = m_pages[3:0];
            endcase
            mw   = tb_scr_layer.map_mem[{page, y[7:3], x[8:3]}];
            tw   = tb_scr_layer.tile_mem[{mw[12:0], y[2:0]}];
            b    = 7 - int'(x[2:0]);       // msb is leftmost pixel
            dest = m_ctrl[0] ? line_w - 1 - c : c;
            pend[dest] = {mw[15], mw[11:5], tw[16+b], tw[8+b], tw[b]};
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            m_pages    = '0;
            m_hscr     = '0;
            m_vscr     = '0;
            m_rowscr   = '0;
            m_ctrl     = '0;
            last_lhbl  = 1'b0;
            seen_blank = 1'b0;
            chk_pend   = 1'b0;
            for (int i = 0; i < line_w; i++) begin
                disp[i] = '0;
                pend[i] = '0;
            end
        end else begin
            chk_pend = 1'b0;
            if (last_lhbl && !lhbl) begin   // blank start, swap and snapshot
                seen_blank = 1'b1;
                disp = pend;
                render_line(vrender);
            end
            if (lhbl && hdump < 9'(line_w)) begin
                exp_col  = hdump[7:0];
                exp_pxl  = disp[exp_col];
                disp[exp_col] = '0;         // read erases
                chk_pend = 1'b1;
            end
            if (psel && penable) begin
                if (pready !== 1'b1) begin
                    $display("FAILED pready addr %h: expected 1 got %h", paddr, pready);
                    apb_errs++;
                end
                if (pslverr !== (paddr > 5'd4)) begin
                    $display("FAILED pslverr addr %h: expected %h got %h",
                             paddr, paddr > 5'd4, pslverr);
                    apb_errs++;
                end
                if (!pwrite) begin
                    if (prdata !== reg_value(paddr)) begin
                        $display("FAILED prdata addr %h: expected %h got %h",
                                 paddr, reg_value(paddr), prdata);
                        apb_errs++;
                    end
                end else begin
                    case (paddr)
                        5'd0: m_pages  = pwdata[15:0];
                        5'd1: m_hscr   = pwdata[9:0];
                        5'd2: m_vscr   = pwdata[8:0];
                        5'd3: m_rowscr = pwdata[9:0];
                        5'd4: m_ctrl   = pwdata[1:0];
                        default: ;                  // no effect
                    endcase
                end
            end
            last_lhbl = lhbl;
        end
    end

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (chk_pend && pxl !== exp_pxl) begin
            $display("FAILED pxl col %0d: expected %h got %h", exp_col, exp_pxl, pxl);
            pix_errs++;
        end
        if (!rst && !seen_blank && (map_cs || tile_cs)) begin
            $display("memory request raised before the first blank start");
            pix_errs++;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_scr_layer.sv ====
`default_nettype none

module tb_scr_layer;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int run_lines   = 32;
    localparam int watchdog_ns = (run_lines * 768 + 100) * 20;

    logic            clk = 1'b0;
    logic            rst = 1'b1;
    logic            psel, penable, pwrite;
    logic [4:0]      paddr;
    logic [31:0]     pwdata, prdata;
    logic            pready, pslverr;
    logic            map_cs, map_ok, tile_cs, tile_ok;
    logic [14:0]     map_addr;
    logic [15:0]     map_data;
    logic [15:0]     tile_addr;
    logic [31:0]     tile_data;
    logic            lhbl;
    logic [8:0]      vrender, hdump;
    scr_pkg::pixel_t pxl;
    int              pix_errs, apb_errs;

    logic [15:0] map_mem  [0:32767];
    logic [31:0] tile_mem [0:65535];
    logic [9:0]  hcnt;             // clock within the line
    logic        max_lat;          // every access at 3 cycles
    int          map_cnt, tile_cnt;
    int          map_lat, tile_lat;

    always #10 clk = ~clk;

    scr_layer_top dut0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .map_cs(map_cs), .map_addr(map_addr), .map_data(map_data), .map_ok(map_ok),
        .tile_cs(tile_cs), .tile_addr(tile_addr), .tile_data(tile_data),
        .tile_ok(tile_ok),
        .lhbl(lhbl), .vrender(vrender), .hdump(hdump), .pxl(pxl)
    );

    scr_checker u_checker (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .map_cs(map_cs), .tile_cs(tile_cs),
        .lhbl(lhbl), .vrender(vrender), .hdump(hdump), .pxl(pxl),
        .pix_errs(pix_errs), .apb_errs(apb_errs)
    );

    function automatic int pick_latency();
        return max_lat ? 3 : 1 + int'($urandom % 3);
    endfunction

    // 768 clocks per line, last 256 in blank
    always @(negedge clk) begin : video_step
        logic [9:0] nh;
        if (rst) begin
            hcnt    <= '0;
            vrender <= '0;
            lhbl    <= 1'b1;
            hdump   <= '0;
        end else begin
            nh = (hcnt == 10'd767) ? 10'd0 : hcnt + 1'b1;
            hcnt  <= nh;
            lhbl  <= nh < 10'd512;
            hdump <= nh[9:1];       // one column per 2 clocks
            if (hcnt == 10'd767)
                vrender <= (vrender == 9'd261) ? 9'd0 : vrender + 1'b1;
        end
    end

    // map memory, ok after 1 to 3 cycles
    always @(negedge clk) begin
        if (rst || !map_cs || map_ok) begin
            map_ok  <= 1'b0;
            map_cnt <= 0;
        end else begin
            if (map_cnt == 0)
                map_lat = pick_latency();
            if (map_cnt + 1 >= map_lat) begin
                map_ok   <= 1'b1;
                map_data <= map_mem[map_addr];
            end
            map_cnt <= map_cnt + 1;
        end
    end

    // tile memory, same handshake
    always @(negedge clk) begin
        if (rst || !tile_cs || tile_ok) begin
            tile_ok  <= 1'b0;
            tile_cnt <= 0;
        end else begin
            if (tile_cnt == 0)
                tile_lat = pick_latency();
            if (tile_cnt + 1 >= tile_lat) begin
                tile_ok   <= 1'b1;
                tile_data <= tile_mem[tile_addr];
            end
            tile_cnt <= tile_cnt + 1;
        end
    end

    task automatic apb_access(input logic wr, input logic [4:0] a, input logic [31:0] d);
        @(negedge clk);
        psel    = 1'b1;          // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // early in the visible part of the next line
    task automatic next_line();
        @(negedge clk);
        while (hcnt != 10'd16)
            @(negedge clk);
    endtask

    task automatic random_scroll(input logic [1:0] ctrl);
        apb_access(1'b1, 5'd0, $urandom);
        apb_access(1'b1, 5'd1, $urandom);
        apb_access(1'b1, 5'd2, $urandom);
        apb_access(1'b1, 5'd3, $urandom);
        apb_access(1'b1, 5'd4, {30'h0, ctrl});
    endtask

    initial begin
        void'($urandom(76));
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        map_ok    = 1'b0;
        tile_ok   = 1'b0;
        map_data  = '0;
        tile_data = '0;
        lhbl      = 1'b1;
        vrender   = '0;
        hdump     = '0;
        hcnt      = '0;
        max_lat   = 1'b0;
        for (int i = 0; i < 32768; i++)
            map_mem[i] = $urandom;
        for (int i = 0; i < 65536; i++)
            tile_mem[i] = $urandom;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        repeat (2) next_line();          // zero registers, first line blank

        next_line();                     // register readback
        for (int a = 0; a < 5; a++) begin
            apb_access(1'b1, 5'(a), $urandom);
            apb_access(1'b0, 5'(a), '0);
        end
        next_line();                     // unmapped addresses
        for (int k = 0; k < 4; k++) begin
            apb_access(1'b1, 5'(5 + $urandom % 27), $urandom);
            apb_access(1'b0, 5'(5 + $urandom % 27), '0);
        end
        for (int a = 0; a < 5; a++)
            apb_access(1'b0, 5'(a), '0);

        for (int n = 0; n < 6; n++) begin
            next_line();
            random_scroll(2'b00);
        end
        for (int n = 0; n < 4; n++) begin   // row scroll
            next_line();
            random_scroll(2'b10);
        end
        for (int n = 0; n < 5; n++) begin   // flip, last one with row scroll
            next_line();
            random_scroll(n == 4 ? 2'b11 : 2'b01);
        end
        for (int n = 0; n < 4; n++) begin   // cross page edges
            next_line();
            apb_access(1'b1, 5'd0, $urandom);
            apb_access(1'b1, 5'd1, 32'd1023 - ($urandom % 64));
            apb_access(1'b1, 5'd2, 32'd511 - ($urandom % 8));
            apb_access(1'b1, 5'd4, 32'd0);
        end
        max_lat = 1'b1;
        for (int n = 0; n < 4; n++) begin
            next_line();
            random_scroll(2'(n));
        end
        repeat (2) next_line();          // show the last rendered line

        $display("pixel errors %0d, apb errors %0d", pix_errs, apb_errs);
        if (pix_errs + apb_errs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish in the expected time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
